/* tb.f */
+incdir+include
source/pow_5_pkg.sv
source/board_pkg.sv
source/pow_5_pipelined.sv
source/pow_5_multi_cycle.sv
source/seg_display.sv
source/pow_5_top.sv
sim/tb_pow_5_top.sv

/* Makefile */
# Verilator flow for the power-of-five subsystem

VERILATOR = verilator
SIM_BIN   = tb_sim

.PHONY: all lint sim clean

all: sim

# lint the RTL top level only
lint:
	$(VERILATOR) --lint-only --timing -f tb.f --top-module pow_5_top

# build and run the testbench, status follows the pass line
sim:
	$(VERILATOR) --binary --timing --assert -f tb.f \
		--top-module tb_pow_5_top -o $(SIM_BIN)
	./obj_dir/$(SIM_BIN) | tee /dev/stderr | \
		grep -x "TEST RESULT: PASS" > /dev/null

clean:
	rm -rf obj_dir

/* sim/tb_pow_5_top.sv */
`timescale 1ns/100ps

module tb_pow_5_top;

    localparam int W        = 8;
    localparam int TAPS     = 4;
    localparam int DIGITS   = 8;
    localparam int CYCLES   = 3000;
    localparam int WAIT_MAX = 64;

    logic                 clk;
    logic                 rst_n;
    logic                 i_clk_en;
    logic                 i_n_vld;
    logic                 i_seq_vld;
    logic [W - 1:0]       i_n;
    logic [TAPS - 1:0]    o_res_vld;
    logic [TAPS * W - 1:0] o_res;
    logic                 o_seq_busy;
    logic                 o_seq_vld;
    logic [W - 1:0]       o_seq_res;
    logic [DIGITS - 1:0]  o_digit_en;
    logic [DIGITS * 7 - 1:0] o_segments;

    // values applied after the next rising edge
    logic                 drv_en;
    logic                 drv_n_vld;
    logic                 drv_seq_vld;
    logic [W - 1:0]       drv_n;

    integer               seed = 32'hafca_ab97;
    int                   en_low_left;
    int                   dense_left;
    logic                 dense;
    int                   errors;
    int                   timeouts;
    logic                 last_en;

    // model state, index 0 of the history is the newest enabled edge
    logic                 hist_vld [$];
    logic [W - 1:0]       hist_n [$];
    int                   filled;
    int                   seq_left;
    logic [W - 1:0]       seq_n;
    logic                 seq_vld_exp;
    logic [W - 1:0]       seq_res_exp;
    logic                 seq_res_known;

    // outputs seen at the previous check
    logic [TAPS - 1:0]    prev_res_vld;
    logic [TAPS * W - 1:0] prev_res;
    logic                 prev_seq_busy;
    logic                 prev_seq_vld;
    logic [W - 1:0]       prev_seq_res;
    logic [DIGITS - 1:0]  prev_digit_en;
    logic [DIGITS * 7 - 1:0] prev_segments;

    pow_5_top pow_5_top_i
    (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .i_clk_en   ( i_clk_en   ),
        .i_n_vld    ( i_n_vld    ),
        .i_seq_vld  ( i_seq_vld  ),
        .i_n        ( i_n        ),
        .o_res_vld  ( o_res_vld  ),
        .o_res      ( o_res      ),
        .o_seq_busy ( o_seq_busy ),
        .o_seq_vld  ( o_seq_vld  ),
        .o_seq_res  ( o_seq_res  ),
        .o_digit_en ( o_digit_en ),
        .o_segments ( o_segments )
    );

    always
    begin
        #2 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------------

    // n to the p, wrapping at W bits
    function automatic logic [W - 1:0] power_mod(input logic [W - 1:0] n, input int p);
        logic [W - 1:0] r;
        r = W'(1);
        for (int i = 0; i < p; i++)
            r = r * n;
        return r;
    endfunction

    // hex font, segment a in bit 0
    function automatic logic [6:0] hex_font(input logic [3:0] h);
        logic [6:0] s;
        case (h)
            4'h0:    s = 7'h3f;
            4'h1:    s = 7'h06;
            4'h2:    s = 7'h5b;
            4'h3:    s = 7'h4f;
            4'h4:    s = 7'h66;
            4'h5:    s = 7'h6d;
            4'h6:    s = 7'h7d;
            4'h7:    s = 7'h07;
            4'h8:    s = 7'h7f;
            4'h9:    s = 7'h6f;
            4'ha:    s = 7'h77;
            4'hb:    s = 7'h7c;
            4'hc:    s = 7'h39;
            4'hd:    s = 7'h5e;
            4'he:    s = 7'h79;
            default: s = 7'h71;
        endcase
        return s;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp)
        else
        begin
            errors++;
            $display("CHECK FAILED t=%0t %s got %0h exp %0h", $time, name, got, exp);
        end
    endtask

    // called at a rising edge, inputs are stable there
    task automatic model_step;
        last_en = i_clk_en;
        if (i_clk_en)
        begin
            hist_vld.push_front(i_n_vld);
            hist_n.push_front(i_n);
            void'(hist_vld.pop_back());
            void'(hist_n.pop_back());
            if (filled < 6)
                filled++;
            seq_vld_exp = 1'b0;
            // engine stays occupied through the edge that shows the result
            if (seq_left > 0)
            begin
                seq_left--;
                if (seq_left == 0)
                begin
                    seq_vld_exp   = 1'b1;
                    seq_res_exp   = power_mod(seq_n, 5);
                    seq_res_known = 1'b1;
                end
            end
            else if (i_seq_vld)
            begin
                seq_left = 6;
                seq_n    = i_n;
            end
        end
    endtask

    task automatic store_prev;
        prev_res_vld  = o_res_vld;
        prev_res      = o_res;
        prev_seq_busy = o_seq_busy;
        prev_seq_vld  = o_seq_vld;
        prev_seq_res  = o_seq_res;
        prev_digit_en = o_digit_en;
        prev_segments = o_segments;
    endtask

    task automatic check_outputs;
        logic [TAPS - 1:0]   exp_vld;
        logic [DIGITS - 1:0] exp_digit;
        logic [W - 1:0]      word;
        logic [3:0]          nib;
        int                  p;
        // tap t holds power 5 - t
        for (int t = 0; t < TAPS; t++)
            exp_vld[t] = hist_vld[5 - t];
        check_value("o_res_vld", 64'(o_res_vld), 64'(exp_vld));
        for (int t = 0; t < TAPS; t++)
        begin
            if (exp_vld[t])
                check_value($sformatf("o_res[%0d]", t), 64'(o_res[t * W +: W]),
                            64'(power_mod(hist_n[5 - t], 5 - t)));
        end
        for (int d = 0; d < DIGITS; d++)
        begin
            p            = 5 - d / 2;
            exp_digit[d] = exp_vld[d / 2];
            // a tap holds known data once its operand has reached it
            if (filled > p)
            begin
                word = power_mod(hist_n[p], p);
                nib  = word[(d % 2) * 4 +: 4];
                check_value($sformatf("o_segments[%0d]", d), 64'(o_segments[d * 7 +: 7]),
                            64'(hex_font(nib)));
            end
        end
        check_value("o_digit_en", 64'(o_digit_en), 64'(exp_digit));
        check_value("o_seq_busy", 64'(o_seq_busy), 64'(seq_left >= 1 && seq_left <= 5));
        check_value("o_seq_vld", 64'(o_seq_vld), 64'(seq_vld_exp));
        if (seq_res_known)
            check_value("o_seq_res", 64'(o_seq_res), 64'(seq_res_exp));
        // a disabled edge must leave every output alone
        if (!last_en)
        begin
            check_value("o_res_vld held", 64'(o_res_vld), 64'(prev_res_vld));
            check_value("o_res held", 64'(o_res), 64'(prev_res));
            check_value("o_seq_busy held", 64'(o_seq_busy), 64'(prev_seq_busy));
            check_value("o_seq_vld held", 64'(o_seq_vld), 64'(prev_seq_vld));
            check_value("o_seq_res held", 64'(o_seq_res), 64'(prev_seq_res));
            check_value("o_digit_en held", 64'(o_digit_en), 64'(prev_digit_en));
            check_value("o_segments held", 64'(o_segments), 64'(prev_segments));
        end
        store_prev();
    endtask

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------

    task automatic run_cycle;
        @(posedge clk);
        model_step();
        #0.5;
        i_clk_en  = drv_en;
        i_n_vld   = drv_n_vld;
        i_seq_vld = drv_seq_vld;
        i_n       = drv_n;
        @(negedge clk);
        check_outputs();
    endtask

    task automatic pick_random;
        // alternate between back-to-back and sparse operand phases
        if (dense_left == 0)
        begin
            dense      = ~dense;
            dense_left = 16 + ($random(seed) & 31);
        end
        dense_left--;
        if (en_low_left > 0)
        begin
            drv_en = 1'b0;
            en_low_left--;
        end
        else if (($random(seed) & 7) == 0)
        begin
            drv_en      = 1'b0;
            en_low_left = $random(seed) & 3;
        end
        else
        begin
            drv_en = 1'b1;
        end
        if (dense)
            drv_n_vld = (($random(seed) & 7) != 0);
        else
            drv_n_vld = (($random(seed) & 7) == 0);
        drv_seq_vld = (($random(seed) & 3) == 0);
        drv_n       = W'($random(seed));
    endtask

    task automatic wait_seq_idle;
        int n;
        n           = 0;
        drv_en      = 1'b1;
        drv_n_vld   = 1'b0;
        drv_seq_vld = 1'b0;
        // flush any request already on the inputs
        run_cycle();
        while ((o_seq_busy || seq_left != 0) && n < WAIT_MAX)
        begin
            run_cycle();
            n++;
        end
        if (o_seq_busy || seq_left != 0)
        begin
            timeouts++;
            $display("timeout waiting for the iterative engine to go idle at t=%0t", $time);
        end
    endtask

    // request a, then try b while busy, which must be ignored
    task automatic seq_directed(input logic [W - 1:0] a, input logic [W - 1:0] b);
        int   edges;
        int   n;
        logic sent_b;
        logic done;
        wait_seq_idle();
        drv_seq_vld = 1'b1;
        drv_n       = a;
        run_cycle();
        drv_seq_vld = 1'b0;
        edges       = 0;
        n           = 0;
        sent_b      = 1'b0;
        done        = 1'b0;
        while (!done && n < WAIT_MAX)
        begin
            run_cycle();
            n++;
            if (last_en)
                edges++;
            if (o_seq_vld)
            begin
                done = 1'b1;
            end
            else if (o_seq_busy && !sent_b)
            begin
                drv_seq_vld = 1'b1;
                drv_n       = b;
                sent_b      = 1'b1;
            end
            else
            begin
                drv_seq_vld = 1'b0;
            end
        end
        if (!done)
        begin
            timeouts++;
            $display("timeout waiting for o_seq_vld at t=%0t", $time);
        end
        else
        begin
            // edges counts the sampling edge too
            check_value("o_seq_vld latency", 64'(edges - 1), 64'(6));
            check_value("o_seq_res directed", 64'(o_seq_res), 64'(power_mod(a, 5)));
        end
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------

    initial
    begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        i_clk_en      = 1'b0;
        i_n_vld       = 1'b0;
        i_seq_vld     = 1'b0;
        i_n           = '0;
        drv_en        = 1'b0;
        drv_n_vld     = 1'b0;
        drv_seq_vld   = 1'b0;
        drv_n         = '0;
        errors        = 0;
        timeouts      = 0;
        en_low_left   = 0;
        dense_left    = 32;
        dense         = 1'b1;
        filled        = 0;
        seq_left      = 0;
        seq_vld_exp   = 1'b0;
        seq_res_known = 1'b0;
        last_en       = 1'b0;
        for (int i = 0; i < 6; i++)
        begin
            hist_vld.push_back(1'b0);
            hist_n.push_back('0);
        end

        repeat (10)
        begin
            @(posedge clk);
            #0.5;
            check_value("o_res_vld in reset", 64'(o_res_vld), 64'(0));
            check_value("o_seq_busy in reset", 64'(o_seq_busy), 64'(0));
            check_value("o_seq_vld in reset", 64'(o_seq_vld), 64'(0));
            check_value("o_digit_en in reset", 64'(o_digit_en), 64'(0));
        end
        rst_n = 1'b1;
        store_prev();

        repeat (CYCLES)
        begin
            pick_random();
            run_cycle();
        end

        repeat (4)
            seq_directed(W'($random(seed)), W'($random(seed)));

        // let the pipeline drain
        drv_en      = 1'b1;
        drv_n_vld   = 1'b0;
        drv_seq_vld = 1'b0;
        repeat (8)
            run_cycle();

        $display("errors: %0d value, %0d timeout", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* source/pow_5_top.sv */
`timescale 1ns/100ps

module pow_5_top
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 i_clk_en,
    input  logic                 i_n_vld,
    input  logic                 i_seq_vld,
    input  pow_5_pkg::operand_t  i_n,
    output pow_5_pkg::tap_vld_t  o_res_vld,
    output pow_5_pkg::tap_bus_t  o_res,
    output logic                 o_seq_busy,
    output logic                 o_seq_vld,
    output pow_5_pkg::operand_t  o_seq_res,
    output board_pkg::digit_en_t o_digit_en,
    output board_pkg::seg_bus_t  o_segments
);

    // ------------------------------------------------------------------------
    // pipelined engine, one operand per enabled cycle
    // ------------------------------------------------------------------------

    pow_5_pipelined pow_5_pipelined_i
    (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .i_clk_en  ( i_clk_en  ),
        .i_n_vld   ( i_n_vld   ),
        .i_n       ( i_n       ),
        .o_res_vld ( o_res_vld ),
        .o_res     ( o_res     )
    );

    // ------------------------------------------------------------------------
    // iterative engine, shares the operand bus
    // ------------------------------------------------------------------------

    pow_5_multi_cycle pow_5_multi_cycle_i
    (
        .clk       ( clk        ),
        .rst_n     ( rst_n      ),
        .i_clk_en  ( i_clk_en   ),
        .i_n_vld   ( i_seq_vld  ),
        .i_n       ( i_n        ),
        .o_busy    ( o_seq_busy ),
        .o_res_vld ( o_seq_vld  ),
        .o_res     ( o_seq_res  )
    );

    // ------------------------------------------------------------------------
    // display of the pipeline taps
    // ------------------------------------------------------------------------

    seg_display seg_display_i
    (
        .i_res_vld  ( o_res_vld  ),
        .i_res      ( o_res      ),
        .o_digit_en ( o_digit_en ),
        .o_segments ( o_segments )
    );

endmodule

/* source/seg_display.sv */
`timescale 1ns/100ps

module seg_display
(
    input  pow_5_pkg::tap_vld_t  i_res_vld,
    input  pow_5_pkg::tap_bus_t  i_res,
    output board_pkg::digit_en_t o_digit_en,
    output board_pkg::seg_bus_t  o_segments
);

    // two hex digits per 8-bit result
    localparam int DIGITS_PER_TAP = $bits(pow_5_pkg::operand_t) / 4;

    // ------------------------------------------------------------------------
    // hex font, segment a in bit 0
    // ------------------------------------------------------------------------

    function automatic board_pkg::segments_t hex_to_seg(input logic [3:0] nibble);
        board_pkg::segments_t seg;
        case (nibble)
            4'h0:    seg = 7'h3f;
            4'h1:    seg = 7'h06;
            4'h2:    seg = 7'h5b;
            4'h3:    seg = 7'h4f;
            4'h4:    seg = 7'h66;
            4'h5:    seg = 7'h6d;
            4'h6:    seg = 7'h7d;
            4'h7:    seg = 7'h07;
            4'h8:    seg = 7'h7f;
            4'h9:    seg = 7'h6f;
            4'ha:    seg = 7'h77;
            // lower case b and d so they differ from 8 and 0
            4'hb:    seg = 7'h7c;
            4'hc:    seg = 7'h39;
            4'hd:    seg = 7'h5e;
            4'he:    seg = 7'h79;
            default: seg = 7'h71;
        endcase
        return seg;
    endfunction

    // ------------------------------------------------------------------------
    // digit mapping
    // ------------------------------------------------------------------------

    // digit d shows nibble d, so power two lands on the two left digits
    always_comb
    begin
        for (int d = 0; d < board_pkg::DIGITS; d++)
        begin
            o_digit_en[d] = i_res_vld[d / DIGITS_PER_TAP];
            o_segments[d * board_pkg::SEG_W +: board_pkg::SEG_W] =
                hex_to_seg(i_res[d * 4 +: 4]);
        end
    end

endmodule

/* source/pow_5_multi_cycle.sv */
`timescale 1ns/100ps

`include "pow_5_macros.svh"

module pow_5_multi_cycle
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                i_clk_en,
    input  logic                i_n_vld,
    input  pow_5_pkg::operand_t i_n,
    output logic                o_busy,
    output logic                o_res_vld,
    output pow_5_pkg::operand_t o_res
);

    localparam int STEPS = `POW_5_SEQ_STEPS;

    logic                req_q;
    logic                accept;
    logic [STEPS - 1:0]  shift_q;
    logic                res_vld_q;
    pow_5_pkg::operand_t n_q;
    pow_5_pkg::operand_t acc_q;
    pow_5_pkg::operand_t res_q;

    // a pending request also blocks, busy only rises one edge later
    assign accept = i_n_vld && !o_busy && !req_q;
    assign o_busy = |shift_q;

    // ------------------------------------------------------------------------
    // control
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            req_q     <= 1'b0;
            shift_q   <= '0;
            res_vld_q <= 1'b0;
        end
        else if (i_clk_en)
        begin
            req_q     <= accept;
            res_vld_q <= shift_q[0];

            if (req_q)
                shift_q <= STEPS'(1) << (STEPS - 1);
            else
                shift_q <= shift_q >> 1;
        end
    end

    // ------------------------------------------------------------------------
    // datapath, one multiply per step
    // ------------------------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (i_clk_en)
        begin
            if (accept)
                n_q <= i_n;

            if (req_q)
                acc_q <= n_q;
            else if (|shift_q[STEPS - 1:1])
                acc_q <= acc_q * n_q;

            // result held until the next request finishes
            if (shift_q[0])
                res_q <= acc_q;
        end
    end

    assign o_res_vld = res_vld_q;
    assign o_res     = res_q;

    a_shift_onehot : assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(shift_q)
    );

    // idle on an enabled edge means no result right after it
    a_vld_after_busy : assert property (
        @(posedge clk) disable iff (!rst_n)
        (i_clk_en && !o_busy) |=> !o_res_vld
    );

endmodule

/* source/pow_5_pipelined.sv */
`timescale 1ns/100ps

`include "pow_5_macros.svh"

module pow_5_pipelined
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                i_clk_en,
    input  logic                i_n_vld,
    input  pow_5_pkg::operand_t i_n,
    output pow_5_pkg::tap_vld_t o_res_vld,
    output pow_5_pkg::tap_bus_t o_res
);

    localparam int W     = `POW_5_W;
    localparam int DEPTH = `POW_5_DEPTH;

    // vld_q[i] and pow_q[i] belong to the operand sampled i edges ago
    logic [DEPTH:0]      vld_q;
    pow_5_pkg::operand_t n_q   [0:DEPTH - 1];
    pow_5_pkg::operand_t pow_q [2:DEPTH];

    // ------------------------------------------------------------------------
    // valid chain
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            vld_q <= '0;
        end
        else if (i_clk_en)
        begin
            vld_q <= {vld_q[DEPTH - 1:0], i_n_vld};
        end
    end

    // ------------------------------------------------------------------------
    // operand chain and multipliers
    // ------------------------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (i_clk_en)
        begin
            n_q[0] <= i_n;

            for (int i = 1; i < DEPTH; i++)
            begin
                n_q[i] <= n_q[i - 1];
            end

            // first stage squares the delayed operand
            pow_q[2] <= n_q[1] * n_q[1];

            // later stages take one more factor of n each
            for (int i = 3; i <= DEPTH; i++)
            begin
                pow_q[i] <= pow_q[i - 1] * n_q[i - 1];
            end
        end
    end

    // ------------------------------------------------------------------------
    // taps, power two in the top slot
    // ------------------------------------------------------------------------

    always_comb
    begin
        for (int i = 2; i <= DEPTH; i++)
        begin
            o_res_vld[DEPTH - i]         = vld_q[i];
            o_res[(DEPTH - i) * W +: W]  = pow_q[i];
        end
    end

    // no X may travel down the valid chain once out of reset
    a_vld_known : assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(vld_q)
    );

endmodule

/* source/board_pkg.sv */
package board_pkg;

    // ------------------------------------------------------------------------
    // display geometry
    // ------------------------------------------------------------------------

    // eight hex digits on the board
    localparam int DIGITS = 8;

    // segments a to g, no decimal point
    localparam int SEG_W = 7;

    // ------------------------------------------------------------------------
    // display types
    // ------------------------------------------------------------------------

    // segment a in bit 0, a lit segment is 1
    typedef logic [SEG_W - 1:0] segments_t;

    // one enable per digit, digit 0 is the rightmost
    typedef logic [DIGITS - 1:0] digit_en_t;

    // all digit patterns, digit 0 in the low word
    typedef logic [DIGITS * SEG_W - 1:0] seg_bus_t;

endpackage

/* source/pow_5_pkg.sv */
`include "pow_5_macros.svh"

package pow_5_pkg;

    // ------------------------------------------------------------------------
    // arithmetic words
    // ------------------------------------------------------------------------

    // one operand or one power, low W bits only
    typedef logic [`POW_5_W - 1:0] operand_t;

    // ------------------------------------------------------------------------
    // pipeline taps
    // ------------------------------------------------------------------------

    // bit 3 is power two, bit 0 is power five
    typedef logic [`POW_5_STAGES - 1:0] tap_vld_t;

    // power two in the top word, power five in the bottom word
    typedef logic [`POW_5_STAGES * `POW_5_W - 1:0] tap_bus_t;

endpackage

/* include/pow_5_macros.svh */
`ifndef POW_5_MACROS_SVH
`define POW_5_MACROS_SVH

// operand and result width, all arithmetic wraps at this width
`define POW_5_W 8

// result taps on the pipeline, powers two to five
`define POW_5_STAGES 4

// register levels after the input register of the pipeline
`define POW_5_DEPTH (`POW_5_STAGES + 1)

// one-hot step shifter width in the iterative engine
`define POW_5_SEQ_STEPS 5

`endif
